// ==== Bender.yml ====
package:
  name: sl_projector

sources:
  - common/sl_pkg.sv
  - trigger/cam_trigger_ctrl.sv
  - trigger/frame_sequencer.sv
  - pattern/pattern_lut.sv
  - pattern/fringe_phase_gen.sv
  - pattern/sl_pattern_gen.sv
  - hdl/sl_projector_top.sv
  - target: simulation
    files:
      - dv/sl_projector_tb.sv

// ==== common/sl_pkg.sv ====
package sl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // pixel and phase words
  ////////////////////////////////////////////////////////////////////////////

  localparam int PIX_W = 8;                       // one intensity channel
  typedef logic [PIX_W-1:0] pixel_t;

  localparam int PHASE_W = 32;                    // fringe phase accumulator
  typedef logic [PHASE_W-1:0] phase_t;

  // intensity table, indexed by the top bits of the phase
  localparam int LUT_DEPTH = 1024;
  localparam int LUT_AW = 10;
  typedef logic [LUT_AW-1:0] lut_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // frame sequence
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [3:0] frame_idx_t;                // 0..12, 13 frames per set

  localparam frame_idx_t FRAME_LAST = 4'd12;      // wraps to 0 after this
  localparam frame_idx_t FRINGE_FRAMES = 4'd8;    // frames 0..7 are sinusoid

  // 16 fringe periods over 720 rows, 2^32 * 16 / 720
  localparam phase_t PHASE_INC = 32'd95443718;
  // eighth of a period between consecutive fringe frames
  localparam phase_t PHASE_STEP = 32'h2000_0000;

  // frame 8 is flat gray, frames 9..12 are binary stripes
  localparam pixel_t GRAY_LEVEL = 8'd128;
  localparam int STRIPE_LINES = 45;               // lines per band
  localparam int STRIPE_BANDS = 16;               // 4 bit band code

  typedef logic [9:0] line_cnt_t;                 // enough for 720 rows

  ////////////////////////////////////////////////////////////////////////////
  // camera trigger
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [7:0] trig_cnt_t;
  localparam trig_cnt_t TRIG_CNT_MAX = 8'd255;    // count saturates here

  // arming state, encodings kept from the board firmware
  typedef enum logic [2:0] {
    ARM_IDLE       = 3'd0,  // enable low
    ARM_READY_LOW  = 3'd1,  // ready was low when enable rose
    ARM_ROSE       = 3'd2,  // ready rising edge seen
    ARM_FELL       = 3'd3,  // ready falling edge seen
    ARM_READY_HIGH = 3'd4   // ready was high when enable rose
  } arm_state_e;

endpackage

// ==== dv/sl_projector_tb.sv ====
module sl_projector_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic           clk10;
  logic           new_tx_data;
  logic           cam_enable;
  logic           frame_ready;
  logic           vsync;
  logic           hsync;
  logic           frame_active;
  logic           lut_wr;
  sl_pkg::pixel_t lut_data;
  logic           cam_trig;
  logic           cam2_trig;
  logic           frame_sync;
  sl_pkg::pixel_t pixel;

  // reference model of the arming rule, frame count and table
  sl_pkg::arm_state_e m_state;
  sl_pkg::arm_state_e m_sync;        // state seen at the last vsync fall
  sl_pkg::trig_cnt_t  m_cnt;
  logic               m_catch;
  logic               m_enable;
  logic               m_ready;
  sl_pkg::frame_idx_t m_frame;
  int                 m_lines;       // line pulses since frame start
  sl_pkg::pixel_t     m_lut [sl_pkg::LUT_DEPTH];

  int     pixel_errs;
  int     bit_errs;
  int     other_errs;
  integer seed;

  sl_projector_top dut_i (
    .clk10          (clk10),
    .new_tx_data    (new_tx_data),
    .cam_enable_i   (cam_enable),
    .frame_ready_i  (frame_ready),
    .vsync_i        (vsync),
    .hsync_i        (hsync),
    .frame_active_i (frame_active),
    .lut_wr_i       (lut_wr),
    .lut_data_i     (lut_data),
    .cam_trig_o     (cam_trig),
    .cam2_trig_o    (cam2_trig),
    .frame_sync_o   (frame_sync),
    .pixel_o        (pixel)
  );

  initial
  begin
    clk10 = 1'b0;
    forever #5 clk10 = ~clk10;      // 10 ns period
  end

  //////////////////////////////////////////////////////////////////////////
  // compare tasks and expected values
  //////////////////////////////////////////////////////////////////////////

  task automatic check_pixel(input string name, input sl_pkg::pixel_t got,
                             input sl_pkg::pixel_t exp);
    if (got !== exp)
    begin
      pixel_errs++;
      $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      bit_errs++;
      $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  // trigger passes vsync under one of the three arming conditions
  function automatic logic expected_trigger(input sl_pkg::arm_state_e s,
                                            input sl_pkg::trig_cnt_t c, input logic k);
    logic rose;
    rose = (s == sl_pkg::ARM_ROSE);
    return (rose && (c <= 1) && !k) || (rose && (c == 1) && k) ||
           ((s == sl_pkg::ARM_READY_HIGH) && (c == 2));
  endfunction

  function automatic logic expected_frame_sync();
    return (m_frame == 4'd1) || (m_frame == 4'd9);
  endfunction

  function automatic sl_pkg::pixel_t expected_pixel(input sl_pkg::frame_idx_t f,
                                                    input int lines);
    sl_pkg::phase_t ph;
    int             band;
    if (f < sl_pkg::FRINGE_FRAMES)
    begin
      // start offset plus one increment per line, wraps at 2^32
      ph = sl_pkg::phase_t'(f) * sl_pkg::PHASE_STEP + sl_pkg::phase_t'(lines) * sl_pkg::PHASE_INC;
      return m_lut[ph[sl_pkg::PHASE_W-1 -: sl_pkg::LUT_AW]];
    end
    if (f == sl_pkg::FRINGE_FRAMES)
      return sl_pkg::GRAY_LEVEL;
    band = (lines == 0) ? 0 : (lines - 1) / sl_pkg::STRIPE_LINES;  // line 0 joins band 0
    if (band > sl_pkg::STRIPE_BANDS - 1)
      band = sl_pkg::STRIPE_BANDS - 1;
    return band[int'(sl_pkg::FRAME_LAST) - int'(f)] ? 8'hff : 8'h00;  // frame 9 -> bit 3
  endfunction

  // any state change restarts the trigger count
  task automatic change_arm_state(input sl_pkg::arm_state_e s);
    if (s != m_state)
    begin
      m_state = s;
      m_cnt   = '0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////////

  task automatic drive_enable(input logic v);
    @(posedge clk10);
    cam_enable <= v;
    m_enable = v;
    if (!v)
    begin
      change_arm_state(sl_pkg::ARM_IDLE);
      m_frame = '0;                  // sequencer held at frame 0
    end
    else if (m_state == sl_pkg::ARM_IDLE)
      change_arm_state(m_ready ? sl_pkg::ARM_READY_HIGH : sl_pkg::ARM_READY_LOW);
    repeat (4) @(posedge clk10);
    @(negedge clk10);
    check_bit("frame_sync_o", frame_sync, expected_frame_sync());
  endtask

  task automatic drive_ready(input logic v);
    @(posedge clk10);
    frame_ready <= v;
    if (m_enable && (v != m_ready))
      change_arm_state(v ? sl_pkg::ARM_ROSE : sl_pkg::ARM_FELL);
    m_ready = v;
    repeat (4) @(posedge clk10);
  endtask

  task automatic vsync_pulse(output logic hit);
    @(posedge clk10);
    vsync <= 1'b1;
    m_catch = (m_cnt > 1);           // flag latched on the rise
    hit = expected_trigger(m_sync, m_cnt, m_catch);
    repeat (2) @(posedge clk10);
    @(negedge clk10);
    check_bit("cam_trig_o", cam_trig, hit);
    check_bit("cam2_trig_o", cam2_trig, hit);
    @(posedge clk10);
    vsync <= 1'b0;
    m_sync = m_state;                // fall latches the state and counts
    if (m_cnt != sl_pkg::TRIG_CNT_MAX)
      m_cnt = m_cnt + 1'b1;
    if (hit && m_enable)
      m_frame = (m_frame == sl_pkg::FRAME_LAST) ? '0 : m_frame + 1'b1;
    repeat (4) @(posedge clk10);
    @(negedge clk10);
    check_bit("cam_trig_o", cam_trig, 1'b0);
    check_bit("frame_sync_o", frame_sync, expected_frame_sync());
  endtask

  // pulse vsync, re-arming with a ready edge pair until a trigger is due
  task automatic advance_frame();
    logic hit;
    int   tries;
    hit   = 1'b0;
    tries = 0;
    while (!hit && tries < 4)
    begin
      vsync_pulse(hit);
      if (!hit)
      begin
        drive_ready(1'b0);
        drive_ready(1'b1);
      end
      tries++;
    end
    if (!hit)
    begin
      other_errs++;
      $display("** Error at %0t ns: no camera trigger was due after %0d vsync pulses",
               $time, tries);
    end
  endtask

  task automatic goto_frame(input sl_pkg::frame_idx_t f);
    int guard;
    guard = 0;
    while (m_frame != f && guard < 26)
    begin
      advance_frame();
      guard++;
    end
    if (m_frame != f)
    begin
      other_errs++;
      $display("** Error at %0t ns: could not step the sequence to frame %0d", $time, f);
    end
  endtask

  task automatic start_frame();
    @(posedge clk10);
    frame_active <= 1'b0;            // blanking preloads phase, clears lines
    repeat (4) @(posedge clk10);
    frame_active <= 1'b1;
    m_lines = 0;
    repeat (4) @(posedge clk10);
    @(negedge clk10);
    check_pixel("pixel_o", pixel, expected_pixel(m_frame, m_lines));
  endtask

  task automatic line_pulse();
    @(posedge clk10);
    hsync <= 1'b1;
    m_lines++;
    repeat (4) @(posedge clk10);     // pixel lands 4 cycles after the rise
    @(negedge clk10);
    check_pixel("pixel_o", pixel, expected_pixel(m_frame, m_lines));
    @(posedge clk10);
    hsync <= 1'b0;
    repeat (2) @(posedge clk10);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////////

  task automatic load_lut_table();
    sl_pkg::pixel_t b;
    for (int i = 0; i < sl_pkg::LUT_DEPTH + 5; i++)
    begin
      @(posedge clk10);
      if (i < sl_pkg::LUT_DEPTH)
      begin
        b = sl_pkg::pixel_t'($random(seed));
        m_lut[i] = b;
      end
      else
        b = ~m_lut[i - sl_pkg::LUT_DEPTH];  // would show up at entry 0 if taken
      lut_wr   <= 1'b1;
      lut_data <= b;
    end
    @(posedge clk10);
    lut_wr <= 1'b0;
  endtask

  task automatic arming_and_trigger();
    logic hit;
    repeat (2) vsync_pulse(hit);     // nothing armed yet
    drive_enable(1'b1);              // ready low at enable
    vsync_pulse(hit);
    drive_ready(1'b1);
    repeat (4) vsync_pulse(hit);     // count runs past 1
    drive_enable(1'b0);
    repeat (3) vsync_pulse(hit);
    drive_enable(1'b1);              // ready high at enable
    repeat (4) vsync_pulse(hit);
    drive_enable(1'b0);
  endtask

  task automatic frame_sequence();
    drive_ready(1'b0);
    drive_enable(1'b1);
    for (int i = 0; i < 14; i++)
      advance_frame();               // 0..12, wrap, then frame 1
    drive_enable(1'b0);              // back to frame 0
  endtask

  task automatic fringe_frames();
    drive_enable(1'b1);
    for (int f = 0; f < sl_pkg::FRINGE_FRAMES; f++)
    begin
      goto_frame(sl_pkg::frame_idx_t'(f));
      start_frame();
      repeat (40) line_pulse();
    end
  endtask

  task automatic gray_and_stripes();
    for (int f = sl_pkg::FRINGE_FRAMES; f <= sl_pkg::FRAME_LAST; f++)
    begin
      goto_frame(sl_pkg::frame_idx_t'(f));
      start_frame();
      repeat ((f == sl_pkg::FRINGE_FRAMES) ? 40 : 730) line_pulse();  // past the last band
    end
  endtask

  // cycle budget of all tests, worst case re-arming per frame step
  function automatic int test_length_cycles();
    int vs;
    int drv;
    int line;
    int adv;
    int total;
    vs    = 10;
    drv   = 6;
    line  = 9;
    adv   = 3 * vs + 4 * drv;
    total = 20 + sl_pkg::LUT_DEPTH + 16;
    total += 14 * vs + 6 * drv;
    total += 3 * drv + 14 * adv;
    total += drv + 13 * (adv + 10 + line);
    total += (8 * 40 + 40 + 4 * 730) * line;
    return 2 * total;
  endfunction

  initial
  begin
    int limit;
    limit = test_length_cycles();
    repeat (limit) @(posedge clk10);
    $display("** Error: watchdog expired after %0d cycles, tests did not finish", limit);
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    new_tx_data  = 1'b1;
    cam_enable   = 1'b0;
    frame_ready  = 1'b0;
    vsync        = 1'b0;
    hsync        = 1'b0;
    frame_active = 1'b0;
    lut_wr       = 1'b0;
    lut_data     = '0;
    m_state      = sl_pkg::ARM_IDLE;
    m_sync       = sl_pkg::ARM_IDLE;
    m_cnt        = '0;
    m_catch      = 1'b0;
    m_enable     = 1'b0;
    m_ready      = 1'b0;
    m_frame      = '0;
    m_lines      = 0;
    pixel_errs   = 0;
    bit_errs     = 0;
    other_errs   = 0;
    seed         = 50575;
    repeat (16) @(posedge clk10);
    new_tx_data <= 1'b0;
    repeat (2) @(posedge clk10);
    load_lut_table();
    arming_and_trigger();
    frame_sequence();
    fringe_frames();
    gray_and_stripes();
    repeat (4) @(posedge clk10);
    $display("errors: pixel %0d, bit %0d, other %0d", pixel_errs, bit_errs, other_errs);
    if (pixel_errs + bit_errs + other_errs == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== files.f ====
common/sl_pkg.sv
trigger/cam_trigger_ctrl.sv
trigger/frame_sequencer.sv
pattern/pattern_lut.sv
pattern/fringe_phase_gen.sv
pattern/sl_pattern_gen.sv
hdl/sl_projector_top.sv
dv/sl_projector_tb.sv

// ==== hdl/sl_projector_top.sv ====
module sl_projector_top (
  input  logic           clk10,
  input  logic           new_tx_data,
  input  logic           cam_enable_i,    // camera enable
  input  logic           frame_ready_i,   // camera frame-trigger-ready
  input  logic           vsync_i,
  input  logic           hsync_i,
  input  logic           frame_active_i,
  input  logic           lut_wr_i,
  input  sl_pkg::pixel_t lut_data_i,
  output logic           cam_trig_o,      // first camera trigger pin
  output logic           cam2_trig_o,     // second camera, same trigger
  output logic           frame_sync_o,
  output sl_pkg::pixel_t pixel_o
);

  sl_pkg::frame_idx_t frame_idx;   // shared by pattern and phase paths

  ////////////////////////////////////////////////////////////////////////////
  // trigger half
  ////////////////////////////////////////////////////////////////////////////

  cam_trigger_ctrl u_trig (
    .clk10         (clk10),
    .new_tx_data   (new_tx_data),
    .cam_enable_i  (cam_enable_i),
    .frame_ready_i (frame_ready_i),
    .vsync_i       (vsync_i),
    .cam_trig_o    (cam_trig_o)
  );

  assign cam2_trig_o = cam_trig_o;  // both cameras fire together

  frame_sequencer u_seq (
    .clk10        (clk10),
    .new_tx_data  (new_tx_data),
    .cam_enable_i (cam_enable_i),
    .cam_trig_i   (cam_trig_o),     // counts its own triggers
    .frame_idx_o  (frame_idx),
    .frame_sync_o (frame_sync_o)
  );

  // pattern half
  sl_pattern_gen u_pat (
    .clk10          (clk10),
    .new_tx_data    (new_tx_data),
    .hsync_i        (hsync_i),
    .frame_active_i (frame_active_i),
    .frame_idx_i    (frame_idx),
    .lut_wr_i       (lut_wr_i),
    .lut_data_i     (lut_data_i),
    .pixel_o        (pixel_o)
  );

endmodule

// ==== pattern/fringe_phase_gen.sv ====
module fringe_phase_gen (
  input  logic               clk10,
  input  logic               new_tx_data,
  input  logic               frame_active_i,  // low between frames
  input  logic               line_stb_i,      // one pulse per line
  input  sl_pkg::frame_idx_t frame_idx_i,
  output sl_pkg::phase_t     phase_o
);

  logic           fringe;      // frame is one of the sinusoid frames
  sl_pkg::phase_t start_ofs;   // phase at top of frame
  sl_pkg::phase_t step;        // phase added per line

  assign fringe = (frame_idx_i < sl_pkg::FRINGE_FRAMES);

  // frame n starts n eighths of a period in
  assign start_ofs = fringe ? sl_pkg::phase_t'(frame_idx_i) * sl_pkg::PHASE_STEP : '0;
  assign step      = fringe ? sl_pkg::PHASE_INC : '0;

  always_ff @(posedge clk10 or posedge new_tx_data)
  begin
    if (new_tx_data)
    begin
      phase_o <= '0;
    end
    else if (!frame_active_i)
    begin
      phase_o <= start_ofs;                  // preload during blanking
    end
    else if (line_stb_i)
    begin
      phase_o <= phase_o + step;             // wraps modulo 2^32
    end
  end

endmodule

// ==== pattern/pattern_lut.sv ====
module pattern_lut (
  input  logic              clk10,
  input  logic              new_tx_data,
  input  logic              wr_i,        // one byte per strobe
  input  sl_pkg::pixel_t    wr_data_i,
  input  sl_pkg::lut_addr_t rd_addr_i,
  output sl_pkg::pixel_t    rd_data_o    // one cycle after address
);

  sl_pkg::pixel_t         mem [sl_pkg::LUT_DEPTH];
  logic [sl_pkg::LUT_AW:0] wr_ptr;       // one extra bit marks table full
  logic                   wr_en;

  assign wr_en = wr_i && (wr_ptr < (sl_pkg::LUT_AW + 1)'(sl_pkg::LUT_DEPTH));

  // load pointer, stops once every entry is written
  always_ff @(posedge clk10 or posedge new_tx_data)
  begin
    if (new_tx_data)
      wr_ptr <= '0;
    else if (wr_en)
      wr_ptr <= wr_ptr + 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // table storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk10)
  begin
    if (wr_en)
      mem[wr_ptr[sl_pkg::LUT_AW-1:0]] <= wr_data_i;
    rd_data_o <= mem[rd_addr_i];                // block ram style read
  end

endmodule

// ==== pattern/sl_pattern_gen.sv ====
module sl_pattern_gen (
  input  logic               clk10,
  input  logic               new_tx_data,
  input  logic               hsync_i,         // rising edge marks a line
  input  logic               frame_active_i,
  input  sl_pkg::frame_idx_t frame_idx_i,
  input  logic               lut_wr_i,        // serial byte strobe
  input  sl_pkg::pixel_t     lut_data_i,
  output sl_pkg::pixel_t     pixel_o
);

  typedef logic [$clog2(sl_pkg::STRIPE_LINES)-1:0] stripe_cnt_t;
  typedef logic [$clog2(sl_pkg::STRIPE_BANDS)-1:0] band_t;

  logic              hsync_q;
  logic              line_stb_q;   // line strobe, one cycle behind the edge
  sl_pkg::line_cnt_t line_cnt;
  stripe_cnt_t       stripe_cnt;   // line position inside the band
  band_t             band;
  sl_pkg::phase_t    phase;
  sl_pkg::pixel_t    lut_q;        // table value, same stage as pat_q
  sl_pkg::pixel_t    pat_val;
  sl_pkg::pixel_t    pat_q;
  logic              fringe_q;

  fringe_phase_gen u_phase (
    .clk10          (clk10),
    .new_tx_data    (new_tx_data),
    .frame_active_i (frame_active_i),
    .line_stb_i     (line_stb_q),
    .frame_idx_i    (frame_idx_i),
    .phase_o        (phase)
  );

  pattern_lut u_lut (
    .clk10       (clk10),
    .new_tx_data (new_tx_data),
    .wr_i        (lut_wr_i),
    .wr_data_i   (lut_data_i),
    .rd_addr_i   (phase[sl_pkg::PHASE_W-1 -: sl_pkg::LUT_AW]),  // top ten bits
    .rd_data_o   (lut_q)
  );

  ////////////////////////////////////////////////////////////////////////////
  // line and band counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk10 or posedge new_tx_data)
  begin
    if (new_tx_data)
    begin
      hsync_q    <= 1'b0;
      line_stb_q <= 1'b0;
      line_cnt   <= '0;
      stripe_cnt <= '0;
      band       <= '0;
    end
    else
    begin
      hsync_q    <= hsync_i;
      line_stb_q <= hsync_i & ~hsync_q;
      if (!frame_active_i)
      begin
        line_cnt   <= '0;                   // blanking, restart at top
        stripe_cnt <= '0;
        band       <= '0;
      end
      else if (line_stb_q)
      begin
        if (line_cnt != '1)
          line_cnt <= line_cnt + 1'b1;
        // line 0 and lines 1..45 share band 0
        if (line_cnt == '0)
          stripe_cnt <= '0;
        else if (stripe_cnt == stripe_cnt_t'(sl_pkg::STRIPE_LINES - 1))
        begin
          stripe_cnt <= '0;
          if (band != band_t'(sl_pkg::STRIPE_BANDS - 1))
            band <= band + 1'b1;            // stick at the last band
        end
        else
          stripe_cnt <= stripe_cnt + 1'b1;
      end
    end
  end

  // gray and stripe frames, msb of band first
  always_comb
  begin
    case (frame_idx_i)
      sl_pkg::FRINGE_FRAMES: pat_val = sl_pkg::GRAY_LEVEL;
      4'd9:                  pat_val = {sl_pkg::PIX_W{band[3]}};
      4'd10:                 pat_val = {sl_pkg::PIX_W{band[2]}};
      4'd11:                 pat_val = {sl_pkg::PIX_W{band[1]}};
      4'd12:                 pat_val = {sl_pkg::PIX_W{band[0]}};
      default:               pat_val = '0;
    endcase
  end

  // stripe value waits one stage to line up with the table read
  always_ff @(posedge clk10 or posedge new_tx_data)
  begin
    if (new_tx_data)
    begin
      pat_q    <= '0;
      fringe_q <= 1'b0;
    end
    else
    begin
      pat_q    <= pat_val;
      fringe_q <= (frame_idx_i < sl_pkg::FRINGE_FRAMES);
    end
  end

  always_ff @(posedge clk10 or posedge new_tx_data)
  begin
    if (new_tx_data)
      pixel_o <= '0;
    else
      pixel_o <= fringe_q ? lut_q : pat_q;  // 4 cycles after hsync rise
  end

endmodule

// ==== trigger/cam_trigger_ctrl.sv ====
module cam_trigger_ctrl (
  input  logic clk10,
  input  logic new_tx_data,
  input  logic cam_enable_i,   // camera enable level
  input  logic frame_ready_i,  // camera frame-trigger-ready level
  input  logic vsync_i,        // projector vsync, active high
  output logic cam_trig_o      // gated copy of vsync
);

  logic ready_q;               // delayed copies for edge detect
  logic vsync_q;
  logic ready_rise;
  logic ready_fall;
  logic vsync_rise;
  logic vsync_fall;

  sl_pkg::arm_state_e state;
  sl_pkg::arm_state_e prev_state;
  sl_pkg::arm_state_e sync_state;  // state sampled at vsync fall
  sl_pkg::trig_cnt_t  trig_cnt;
  logic               catch_up;    // count ran past 1 at last vsync rise

  assign ready_rise = frame_ready_i & ~ready_q;
  assign ready_fall = ~frame_ready_i & ready_q;
  assign vsync_rise = vsync_i & ~vsync_q;
  assign vsync_fall = ~vsync_i & vsync_q;

  ////////////////////////////////////////////////////////////////////////////
  // arming FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk10 or posedge new_tx_data)
  begin
    if (new_tx_data)
    begin
      ready_q <= 1'b0;
      vsync_q <= 1'b0;
      state   <= sl_pkg::ARM_IDLE;
    end
    else
    begin
      ready_q <= frame_ready_i;
      vsync_q <= vsync_i;
      if (!cam_enable_i)
        state <= sl_pkg::ARM_IDLE;             // camera not armed
      else if (ready_fall)
        state <= sl_pkg::ARM_FELL;
      else if (ready_rise)
        state <= sl_pkg::ARM_ROSE;
      else if (state == sl_pkg::ARM_IDLE)
      begin
        // enable just came up, remember where ready stood
        state <= frame_ready_i ? sl_pkg::ARM_READY_HIGH : sl_pkg::ARM_READY_LOW;
      end
    end
  end

  // sync state and trigger count, both advance on vsync fall
  always_ff @(posedge clk10 or posedge new_tx_data)
  begin
    if (new_tx_data)
    begin
      prev_state <= sl_pkg::ARM_IDLE;
      sync_state <= sl_pkg::ARM_IDLE;
      trig_cnt   <= '0;
      catch_up   <= 1'b0;
    end
    else
    begin
      prev_state <= state;
      if (vsync_fall)
        sync_state <= state;
      if (state != prev_state)
        trig_cnt <= '0;                        // restart on any state change
      else if (vsync_fall && trig_cnt != sl_pkg::TRIG_CNT_MAX)
        trig_cnt <= trig_cnt + 1'b1;           // saturating
      if (vsync_rise)
        catch_up <= (trig_cnt > sl_pkg::trig_cnt_t'(1));
    end
  end

  // vsync passes straight through, no clock in the path
  assign cam_trig_o = vsync_i &
                      (((sync_state == sl_pkg::ARM_ROSE) &&
                        (trig_cnt <= sl_pkg::trig_cnt_t'(1)) && !catch_up) ||
                       ((sync_state == sl_pkg::ARM_ROSE) &&
                        (trig_cnt == sl_pkg::trig_cnt_t'(1)) && catch_up) ||
                       ((sync_state == sl_pkg::ARM_READY_HIGH) &&
                        (trig_cnt == sl_pkg::trig_cnt_t'(2))));

endmodule

// ==== trigger/frame_sequencer.sv ====
module frame_sequencer (
  input  logic               clk10,
  input  logic               new_tx_data,
  input  logic               cam_enable_i,  // low holds frame 0
  input  logic               cam_trig_i,    // camera trigger, one per frame
  output sl_pkg::frame_idx_t frame_idx_o,
  output logic               frame_sync_o   // second camera line
);

  logic               trig_q;
  logic               trig_stb_q;   // registered rising edge of trigger
  sl_pkg::frame_idx_t frame_nxt;

  always_comb
  begin
    frame_nxt = frame_idx_o;
    if (!cam_enable_i)
      frame_nxt = '0;
    else if (trig_stb_q)
      frame_nxt = (frame_idx_o == sl_pkg::FRAME_LAST) ? '0 : frame_idx_o + 1'b1;
  end

  always_ff @(posedge clk10 or posedge new_tx_data)
  begin
    if (new_tx_data)
    begin
      trig_q       <= 1'b0;
      trig_stb_q   <= 1'b0;
      frame_idx_o  <= '0;
      frame_sync_o <= 1'b0;
    end
    else
    begin
      trig_q       <= cam_trig_i;
      trig_stb_q   <= cam_trig_i & ~trig_q;
      frame_idx_o  <= frame_nxt;
      frame_sync_o <= (frame_nxt[2:0] == 3'd1);  // frames 1 and 9
    end
  end

endmodule
